// ==== div_pkg.sv ====
package div_pkg;

  // --------------------------------------------------
  // bus geometry
  // --------------------------------------------------
  localparam int AXIL_ADDR_W = 5;
  localparam int AXIL_DATA_W = 32;

  // register offsets, one word each
  typedef enum logic [AXIL_ADDR_W-1:0] {
    REG_DIVIDEND  = 5'h00,
    REG_DIVISOR   = 5'h04,
    REG_CTRL      = 5'h08,
    REG_STATUS    = 5'h0C,
    REG_QUOTIENT  = 5'h10,
    REG_REMAINDER = 5'h14
  } reg_addr_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axil_resp_e;

  // --------------------------------------------------
  // divider opcodes and controller states
  // --------------------------------------------------
  typedef enum logic {
    OP_UNSIGNED = 1'b0,
    OP_SIGNED   = 1'b1
  } div_op_e;

  typedef enum logic [3:0] {
    S_IDLE,
    S_NEG_DIVISOR,
    S_NEG_DIVIDEND,
    S_SHIFT,
    S_ITER,
    S_REPAIR,
    S_NEG_REM,
    S_NEG_QUO,
    S_DONE
  } div_state_e;

  // control word fields
  localparam int CTRL_START_BIT  = 0;
  localparam int CTRL_SIGNED_BIT = 1;

  // status word fields
  localparam int STATUS_BUSY_BIT = 0;
  localparam int STATUS_DONE_BIT = 1;
  localparam int STATUS_DZ_BIT   = 2;

endpackage

// ==== div_axil_decode.sv ====
`timescale 1ns/1ps

module div_axil_decode
  import div_pkg::*;
#(
  parameter int width_p = 32
) (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  // write address, data and response
  input  logic [AXIL_ADDR_W-1:0] awaddr_i,
  input  logic                   awvalid_i,
  output logic                   awready_o,
  input  logic [AXIL_DATA_W-1:0] wdata_i,
  input  logic                   wvalid_i,
  output logic                   wready_o,
  output axil_resp_e             bresp_o,
  output logic                   bvalid_o,
  input  logic                   bready_i,
  // read address and data
  input  logic [AXIL_ADDR_W-1:0] araddr_i,
  input  logic                   arvalid_i,
  output logic                   arready_o,
  output logic [AXIL_DATA_W-1:0] rdata_o,
  output axil_resp_e             rresp_o,
  output logic                   rvalid_o,
  input  logic                   rready_i,
  // execute and result status
  input  logic                   exec_ready_i,
  input  logic                   res_done_i,
  input  logic                   res_dz_i,
  input  logic [width_p-1:0]     res_quotient_i,
  input  logic [width_p-1:0]     res_remainder_i,
  // start request towards execute
  output logic                   start_v_o,
  output div_op_e                op_o,
  output logic [width_p-1:0]     dividend_o,
  output logic [width_p-1:0]     divisor_o
);

  logic                   wr_hs;
  logic                   rd_hs;
  axil_resp_e             wr_resp;
  axil_resp_e             rd_resp;
  logic [AXIL_DATA_W-1:0] rd_data;
  logic [width_p-1:0]     dividend_r;
  logic [width_p-1:0]     divisor_r;

  // --------------------------------------------------
  // write path
  // --------------------------------------------------
  // AW and W are taken together, and only with no B response outstanding
  assign awready_o = awvalid_i & wvalid_i & ~bvalid_o;
  assign wready_o  = awready_o;
  assign wr_hs     = awvalid_i & awready_o;

  // the opcode rides along with the start pulse
  assign op_o = div_op_e'(wdata_i[CTRL_SIGNED_BIT]);

  always_comb begin
    wr_resp   = RESP_OKAY;
    start_v_o = 1'b0;
    case (awaddr_i)
      REG_DIVIDEND, REG_DIVISOR: begin
        wr_resp = RESP_OKAY;
      end
      REG_CTRL: begin
        if (wdata_i[CTRL_START_BIT]) begin
          // a start while busy is rejected
          if (exec_ready_i) begin
            start_v_o = wr_hs;
          end else begin
            wr_resp = RESP_SLVERR;
          end
        end
      end
      default: begin
        wr_resp = RESP_SLVERR;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      bvalid_o <= 1'b0;
      bresp_o  <= RESP_OKAY;
    end else if (wr_hs) begin
      bvalid_o <= 1'b1;
      bresp_o  <= wr_resp;
    end else if (bready_i) begin
      bvalid_o <= 1'b0;
    end
  end

  // operand registers, only the low width_p bits are kept
  always_ff @(posedge clk_i) begin
    if (wr_hs && awaddr_i == REG_DIVIDEND) begin
      dividend_r <= wdata_i[width_p-1:0];
    end
    if (wr_hs && awaddr_i == REG_DIVISOR) begin
      divisor_r <= wdata_i[width_p-1:0];
    end
  end

  assign dividend_o = dividend_r;
  assign divisor_o  = divisor_r;

  // --------------------------------------------------
  // read path
  // --------------------------------------------------
  assign arready_o = ~rvalid_o;
  assign rd_hs     = arvalid_i & arready_o;

  always_comb begin
    rd_data = '0;
    rd_resp = RESP_OKAY;
    case (araddr_i)
      REG_DIVIDEND:  rd_data = AXIL_DATA_W'(dividend_r);
      REG_DIVISOR:   rd_data = AXIL_DATA_W'(divisor_r);
      REG_CTRL:      rd_data = '0;
      REG_STATUS: begin
        // busy is simply execute not being idle
        rd_data[STATUS_BUSY_BIT] = ~exec_ready_i;
        rd_data[STATUS_DONE_BIT] = res_done_i;
        rd_data[STATUS_DZ_BIT]   = res_dz_i;
      end
      REG_QUOTIENT:  rd_data = AXIL_DATA_W'(res_quotient_i);
      REG_REMAINDER: rd_data = AXIL_DATA_W'(res_remainder_i);
      default: begin
        rd_resp = RESP_SLVERR;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_o <= 1'b0;
      rresp_o  <= RESP_OKAY;
    end else if (rd_hs) begin
      rvalid_o <= 1'b1;
      rresp_o  <= rd_resp;
    end else if (rready_i) begin
      rvalid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_hs) begin
      rdata_o <= rd_data;
    end
  end

endmodule

// ==== div_iter_ctrl.sv ====
`timescale 1ns/1ps

module div_iter_ctrl
  import div_pkg::*;
#(
  parameter int width_p = 32
) (
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  logic       v_i,
  output logic       ready_o,
  input  logic       zero_divisor_i,
  input  logic       signed_r_i,
  input  logic       adder_neg_i,
  input  logic       opa_neg_i,
  input  logic       opc_neg_i,
  output logic [1:0] opa_sel_o,
  output logic       opa_ld_o,
  output logic       opa_inv_o,
  output logic       opa_clr_o,
  output logic [2:0] opb_sel_o,
  output logic       opb_ld_o,
  output logic       opb_inv_o,
  output logic       opb_clr_o,
  output logic [2:0] opc_sel_o,
  output logic       opc_ld_o,
  output logic       latch_op_o,
  output logic       adder_cin_o,
  output logic       v_o,
  input  logic       yumi_i
);

  localparam int CNT_W = $clog2(width_p + 1);

  div_state_e       state_r;
  div_state_e       state_nxt;
  logic [CNT_W-1:0] cnt_r;
  logic             last_iter;
  logic             add_neg_r;
  logic             q_neg_r;
  logic             r_neg_r;

  // width_p+1 iterations, counted 0 .. width_p
  assign last_iter = (cnt_r == CNT_W'(width_p));

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_r   <= S_IDLE;
      cnt_r     <= '0;
      add_neg_r <= 1'b0;
      q_neg_r   <= 1'b0;
      r_neg_r   <= 1'b0;
    end else begin
      state_r   <= state_nxt;
      // sign of the last sum picks add or subtract next cycle
      add_neg_r <= adder_neg_i;
      if (state_r == S_SHIFT) begin
        cnt_r <= '0;
      end else if (state_r == S_ITER) begin
        cnt_r <= cnt_r + CNT_W'(1);
      end
      // raw operand signs are still in A and C here
      if (state_r == S_NEG_DIVISOR) begin
        q_neg_r <= (opa_neg_i ^ opc_neg_i) & signed_r_i;
        r_neg_r <= opc_neg_i & signed_r_i;
      end
    end
  end

  // mux selects are one-hot, bit 0 is the shift or adder path
  always_comb begin
    state_nxt   = state_r;
    latch_op_o  = 1'b0;
    opa_sel_o   = 2'b01;
    opa_ld_o    = 1'b0;
    opa_inv_o   = 1'b0;
    opa_clr_o   = 1'b0;
    opb_sel_o   = 3'b001;
    opb_ld_o    = 1'b0;
    opb_inv_o   = 1'b0;
    opb_clr_o   = 1'b0;
    opc_sel_o   = 3'b001;
    opc_ld_o    = 1'b0;
    adder_cin_o = 1'b0;
    case (state_r)
      S_IDLE: begin
        if (v_i) begin
          latch_op_o = 1'b1;
          opa_sel_o  = 2'b10;
          opa_ld_o   = 1'b1;
          opc_sel_o  = 3'b100;
          opc_ld_o   = 1'b1;
          state_nxt  = S_NEG_DIVISOR;
        end
      end
      S_NEG_DIVISOR: begin
        // A <= |A|, B picks up the dividend for the next step
        opa_ld_o    = 1'b1;
        opa_inv_o   = opa_neg_i;
        adder_cin_o = opa_neg_i;
        opb_clr_o   = 1'b1;
        opb_sel_o   = 3'b100;
        opb_ld_o    = 1'b1;
        state_nxt   = S_NEG_DIVIDEND;
      end
      S_NEG_DIVIDEND: begin
        opa_clr_o   = 1'b1;
        opb_inv_o   = opc_neg_i;
        adder_cin_o = opc_neg_i;
        opc_sel_o   = 3'b010;
        opc_ld_o    = 1'b1;
        state_nxt   = S_SHIFT;
      end
      S_SHIFT: begin
        // adder gives zero, so B gets just the dividend msb
        opa_clr_o = 1'b1;
        opb_clr_o = 1'b1;
        opb_ld_o  = 1'b1;
        opc_ld_o  = 1'b1;
        state_nxt = S_ITER;
      end
      S_ITER: begin
        // non-restoring step: subtract after a positive sum, add otherwise
        opa_inv_o   = ~add_neg_r;
        adder_cin_o = ~add_neg_r;
        opb_ld_o    = 1'b1;
        opc_ld_o    = 1'b1;
        if (last_iter) begin
          opb_sel_o = 3'b010;
          state_nxt = S_REPAIR;
        end
      end
      S_REPAIR: begin
        // add the divisor back if the final remainder came out negative
        opa_clr_o = ~add_neg_r;
        opa_ld_o  = 1'b1;
        state_nxt = S_NEG_REM;
      end
      S_NEG_REM: begin
        opa_inv_o   = r_neg_r;
        adder_cin_o = r_neg_r;
        opa_ld_o    = 1'b1;
        opb_clr_o   = 1'b1;
        opb_sel_o   = 3'b100;
        opb_ld_o    = 1'b1;
        state_nxt   = S_NEG_QUO;
      end
      S_NEG_QUO: begin
        // quotient stays all ones on a zero divisor
        opa_clr_o   = 1'b1;
        opb_inv_o   = q_neg_r & ~zero_divisor_i;
        adder_cin_o = q_neg_r & ~zero_divisor_i;
        opc_sel_o   = 3'b010;
        opc_ld_o    = 1'b1;
        state_nxt   = S_DONE;
      end
      S_DONE: begin
        if (yumi_i) begin
          state_nxt = S_IDLE;
        end
      end
      default: begin
        state_nxt = S_IDLE;
      end
    endcase
  end

  assign ready_o = (state_r == S_IDLE);
  assign v_o     = (state_r == S_DONE);

endmodule

// ==== div_iterative.sv ====
`timescale 1ns/1ps

module div_iterative
  import div_pkg::*;
#(
  parameter int width_p = 32
) (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               v_i,
  output logic               ready_o,
  input  div_op_e            op_i,
  input  logic [width_p-1:0] dividend_i,
  input  logic [width_p-1:0] divisor_i,
  output logic               v_o,
  output logic [width_p-1:0] quotient_o,
  output logic [width_p-1:0] remainder_o,
  output logic               zero_divisor_o,
  input  logic               yumi_i
);

  logic [width_p:0] opa_r;
  logic [width_p:0] opb_r;
  logic [width_p:0] opc_r;
  logic [width_p:0] opa_mux;
  logic [width_p:0] opb_mux;
  logic [width_p:0] opc_mux;
  logic [width_p:0] add_in0;
  logic [width_p:0] add_in1;
  logic [width_p:0] add_out;
  logic [1:0]       opa_sel;
  logic [2:0]       opb_sel;
  logic [2:0]       opc_sel;
  logic             opa_ld;
  logic             opb_ld;
  logic             opc_ld;
  logic             opa_inv;
  logic             opb_inv;
  logic             opa_clr;
  logic             opb_clr;
  logic             adder_cin;
  logic             latch_op;
  logic             signed_r;
  logic             divisor_msb;
  logic             dividend_msb;
  logic             dz_chk_r;
  logic             dz_r;

  // sign extension to width_p+1 only for signed operations
  assign divisor_msb  = (op_i == OP_SIGNED) & divisor_i[width_p-1];
  assign dividend_msb = (op_i == OP_SIGNED) & dividend_i[width_p-1];

  // --------------------------------------------------
  // one-hot operand muxes and registers
  // --------------------------------------------------
  assign opa_mux = ({(width_p+1){opa_sel[1]}} & {divisor_msb, divisor_i})
                 | ({(width_p+1){opa_sel[0]}} & add_out);

  assign opb_mux = ({(width_p+1){opb_sel[2]}} & opc_r)
                 | ({(width_p+1){opb_sel[1]}} & add_out)
                 | ({(width_p+1){opb_sel[0]}} & {add_out[width_p-1:0], opc_r[width_p]});

  // quotient bits enter C from the right as the dividend leaves on the left
  assign opc_mux = ({(width_p+1){opc_sel[2]}} & {dividend_msb, dividend_i})
                 | ({(width_p+1){opc_sel[1]}} & add_out)
                 | ({(width_p+1){opc_sel[0]}} & {opc_r[width_p-1:0], ~add_out[width_p]});

  always_ff @(posedge clk_i) begin
    if (opa_ld) begin
      opa_r <= opa_mux;
    end
    if (opb_ld) begin
      opb_r <= opb_mux;
    end
    if (opc_ld) begin
      opc_r <= opc_mux;
    end
    if (latch_op) begin
      signed_r <= (op_i == OP_SIGNED);
    end
  end

  // --------------------------------------------------
  // adder with invert and clear gating
  // --------------------------------------------------
  assign add_in0 = (opa_r ^ {(width_p+1){opa_inv}}) & ~{(width_p+1){opa_clr}};
  assign add_in1 = (opb_r ^ {(width_p+1){opb_inv}}) & ~{(width_p+1){opb_clr}};
  assign add_out = add_in0 + add_in1 + {{width_p{1'b0}}, adder_cin};

  // A holds the raw divisor the cycle after the latch
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dz_chk_r <= 1'b0;
      dz_r     <= 1'b0;
    end else begin
      dz_chk_r <= latch_op;
      if (dz_chk_r) begin
        dz_r <= ~(|opa_r);
      end
    end
  end

  assign remainder_o    = opa_r[width_p-1:0];
  assign quotient_o     = opc_r[width_p-1:0];
  assign zero_divisor_o = dz_r;

  div_iter_ctrl #(
    .width_p(width_p)
  ) u_ctrl (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .v_i           (v_i),
    .ready_o       (ready_o),
    .zero_divisor_i(dz_r),
    .signed_r_i    (signed_r),
    .adder_neg_i   (add_out[width_p]),
    .opa_neg_i     (opa_r[width_p]),
    .opc_neg_i     (opc_r[width_p]),
    .opa_sel_o     (opa_sel),
    .opa_ld_o      (opa_ld),
    .opa_inv_o     (opa_inv),
    .opa_clr_o     (opa_clr),
    .opb_sel_o     (opb_sel),
    .opb_ld_o      (opb_ld),
    .opb_inv_o     (opb_inv),
    .opb_clr_o     (opb_clr),
    .opc_sel_o     (opc_sel),
    .opc_ld_o      (opc_ld),
    .latch_op_o    (latch_op),
    .adder_cin_o   (adder_cin),
    .v_o           (v_o),
    .yumi_i        (yumi_i)
  );

endmodule

// ==== div_result.sv ====
`timescale 1ns/1ps

module div_result #(
  parameter int width_p = 32
) (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               v_i,
  input  logic [width_p-1:0] quotient_i,
  input  logic [width_p-1:0] remainder_i,
  input  logic               zero_divisor_i,
  input  logic               start_i,
  output logic               yumi_o,
  output logic               done_o,
  output logic               dz_o,
  output logic [width_p-1:0] quotient_o,
  output logic [width_p-1:0] remainder_o
);

  logic [width_p-1:0] quotient_r;
  logic [width_p-1:0] remainder_r;
  logic               done_r;
  logic               dz_r;

  // always room for a new result, so take it right away
  assign yumi_o = v_i;

  always_ff @(posedge clk_i) begin
    if (yumi_o) begin
      quotient_r  <= quotient_i;
      remainder_r <= remainder_i;
    end
  end

  // --------------------------------------------------
  // status flags
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      done_r <= 1'b0;
      dz_r   <= 1'b0;
    end else if (yumi_o) begin
      done_r <= 1'b1;
      dz_r   <= zero_divisor_i;
    end else if (start_i) begin
      // a new division hides the old result
      done_r <= 1'b0;
    end
  end

  assign done_o      = done_r;
  assign dz_o        = dz_r;
  assign quotient_o  = quotient_r;
  assign remainder_o = remainder_r;

endmodule

// ==== div_top.sv ====
`timescale 1ns/1ps

module div_top
  import div_pkg::*;
#(
  parameter int width_p = 32
) (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic [AXIL_ADDR_W-1:0] awaddr_i,
  input  logic                   awvalid_i,
  output logic                   awready_o,
  input  logic [AXIL_DATA_W-1:0] wdata_i,
  input  logic                   wvalid_i,
  output logic                   wready_o,
  output axil_resp_e             bresp_o,
  output logic                   bvalid_o,
  input  logic                   bready_i,
  input  logic [AXIL_ADDR_W-1:0] araddr_i,
  input  logic                   arvalid_i,
  output logic                   arready_o,
  output logic [AXIL_DATA_W-1:0] rdata_o,
  output axil_resp_e             rresp_o,
  output logic                   rvalid_o,
  input  logic                   rready_i
);

  logic               exec_ready;
  logic               start_v;
  div_op_e            op;
  logic [width_p-1:0] dividend;
  logic [width_p-1:0] divisor;
  logic               exec_v;
  logic [width_p-1:0] exec_quotient;
  logic [width_p-1:0] exec_remainder;
  logic               exec_dz;
  logic               res_yumi;
  logic               res_done;
  logic               res_dz;
  logic [width_p-1:0] res_quotient;
  logic [width_p-1:0] res_remainder;

  // register front end
  div_axil_decode #(
    .width_p(width_p)
  ) u_decode (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .awaddr_i       (awaddr_i),
    .awvalid_i      (awvalid_i),
    .awready_o      (awready_o),
    .wdata_i        (wdata_i),
    .wvalid_i       (wvalid_i),
    .wready_o       (wready_o),
    .bresp_o        (bresp_o),
    .bvalid_o       (bvalid_o),
    .bready_i       (bready_i),
    .araddr_i       (araddr_i),
    .arvalid_i      (arvalid_i),
    .arready_o      (arready_o),
    .rdata_o        (rdata_o),
    .rresp_o        (rresp_o),
    .rvalid_o       (rvalid_o),
    .rready_i       (rready_i),
    .exec_ready_i   (exec_ready),
    .res_done_i     (res_done),
    .res_dz_i       (res_dz),
    .res_quotient_i (res_quotient),
    .res_remainder_i(res_remainder),
    .start_v_o      (start_v),
    .op_o           (op),
    .dividend_o     (dividend),
    .divisor_o      (divisor)
  );

  div_iterative #(
    .width_p(width_p)
  ) u_exec (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .v_i           (start_v),
    .ready_o       (exec_ready),
    .op_i          (op),
    .dividend_i    (dividend),
    .divisor_i     (divisor),
    .v_o           (exec_v),
    .quotient_o    (exec_quotient),
    .remainder_o   (exec_remainder),
    .zero_divisor_o(exec_dz),
    .yumi_i        (res_yumi)
  );

  // result capture and status
  div_result #(
    .width_p(width_p)
  ) u_result (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .v_i           (exec_v),
    .quotient_i    (exec_quotient),
    .remainder_i   (exec_remainder),
    .zero_divisor_i(exec_dz),
    .start_i       (start_v),
    .yumi_o        (res_yumi),
    .done_o        (res_done),
    .dz_o          (res_dz),
    .quotient_o    (res_quotient),
    .remainder_o   (res_remainder)
  );

endmodule

// ==== tb_div_top.sv ====
`timescale 1ns/1ps

module tb_div_top
  import div_pkg::*;
();

  localparam int CLK_PERIOD = 40;
  localparam int POLL_LIMIT = 100;
  localparam int N_DIR_U    = 7;
  localparam int N_RAND_U   = 200;
  localparam int N_DIR_S    = 8;
  localparam int N_RAND_S   = 60;
  localparam int N_ZERO     = 4;
  localparam int N_BP       = 24;
  localparam int NUM_TESTS  = N_DIR_U + N_RAND_U + N_DIR_S + N_RAND_S + N_ZERO + N_BP + 4;

  logic                   clk;
  logic                   arst_n;
  logic [AXIL_ADDR_W-1:0] awaddr;
  logic                   awvalid;
  logic                   awready;
  logic [AXIL_DATA_W-1:0] wdata;
  logic                   wvalid;
  logic                   wready;
  axil_resp_e             bresp;
  logic                   bvalid;
  logic                   bready;
  logic [AXIL_ADDR_W-1:0] araddr;
  logic                   arvalid;
  logic                   arready;
  logic [AXIL_DATA_W-1:0] rdata;
  axil_resp_e             rresp;
  logic                   rvalid;
  logic                   rready;

  // max random stall on bready and rready, zero means take at once
  int bp_max;

  // results waiting for the checker
  string                  name_q[$];
  div_op_e                op_q[$];
  logic [AXIL_DATA_W-1:0] a_q[$];
  logic [AXIL_DATA_W-1:0] b_q[$];
  logic [AXIL_DATA_W-1:0] quo_q[$];
  logic [AXIL_DATA_W-1:0] rem_q[$];
  logic                   dz_q[$];
  int                     n_sent;
  int                     n_checked;
  event                   result_ev;

  div_top #(
    .width_p(32)
  ) u_dut (
    .clk_i    (clk),
    .arst_n_i (arst_n),
    .awaddr_i (awaddr),
    .awvalid_i(awvalid),
    .awready_o(awready),
    .wdata_i  (wdata),
    .wvalid_i (wvalid),
    .wready_o (wready),
    .bresp_o  (bresp),
    .bvalid_o (bvalid),
    .bready_i (bready),
    .araddr_i (araddr),
    .arvalid_i(arvalid),
    .arready_o(arready),
    .rdata_o  (rdata),
    .rresp_o  (rresp),
    .rvalid_o (rvalid),
    .rready_i (rready)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // --------------------------------------------------
  // reference model and compare tasks
  // --------------------------------------------------
  function automatic void ref_div(input div_op_e op, input logic [31:0] a, input logic [31:0] b,
                                  output logic [31:0] q, output logic [31:0] r, output logic dz);
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    sa = a;
    sb = b;
    dz = (b == 32'd0);
    if (b == 32'd0) begin
      q = '1;
      r = a;
    end else if (op == OP_SIGNED) begin
      // most negative over minus one overflows
      if (a == 32'h8000_0000 && b == 32'hFFFF_FFFF) begin
        q = a;
        r = '0;
      end else begin
        q = sa / sb;
        r = sa % sb;
      end
    end else begin
      q = a / b;
      r = a % b;
    end
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1, "run stopped at first failure");
  endtask

  task automatic check_data(input string name, input logic [AXIL_DATA_W-1:0] exp,
                            input logic [AXIL_DATA_W-1:0] act);
    if (exp !== act) begin
      report_failure($sformatf("error %s expected 0x%08h actual 0x%08h", name, exp, act));
    end
  endtask

  task automatic check_resp(input string name, input axil_resp_e exp, input axil_resp_e act);
    if (exp !== act) begin
      report_failure($sformatf("error %s expected %s actual %s", name, exp.name(), act.name()));
    end
  endtask

  function automatic int draw_stall();
    if (bp_max > 0) begin
      return $urandom_range(0, bp_max);
    end
    return 0;
  endfunction

  // --------------------------------------------------
  // AXI4-Lite driver tasks
  // --------------------------------------------------
  task automatic axil_write(input logic [AXIL_ADDR_W-1:0] addr,
                            input logic [AXIL_DATA_W-1:0] data, output axil_resp_e resp);
    int         stall;
    logic       accepted;
    axil_resp_e first;
    @(negedge clk);
    awaddr   = addr;
    wdata    = data;
    awvalid  = 1'b1;
    wvalid   = 1'b1;
    accepted = 1'b0;
    // readies seen just ahead of the edge that takes AW and W
    while (!accepted) begin
      @(posedge clk);
      if (awready !== wready) begin
        report_failure("awready and wready did not rise in the same cycle");
      end
      accepted = (awready === 1'b1);
    end
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    if (bvalid !== 1'b1) begin
      report_failure("no B response one cycle after the write was accepted");
    end
    first = bresp;
    stall = draw_stall();
    repeat (stall) begin
      @(negedge clk);
      if (!bvalid || bresp !== first) begin
        report_failure("B response dropped or changed while bready was low");
      end
    end
    resp   = bresp;
    bready = 1'b1;
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic axil_read(input logic [AXIL_ADDR_W-1:0] addr,
                           output logic [AXIL_DATA_W-1:0] data, output axil_resp_e resp);
    int                     stall;
    logic                   accepted;
    logic [AXIL_DATA_W-1:0] first;
    axil_resp_e             first_resp;
    @(negedge clk);
    araddr   = addr;
    arvalid  = 1'b1;
    accepted = 1'b0;
    while (!accepted) begin
      @(posedge clk);
      accepted = (arready === 1'b1);
    end
    @(negedge clk);
    arvalid = 1'b0;
    if (rvalid !== 1'b1) begin
      report_failure("no R response one cycle after the read was accepted");
    end
    first      = rdata;
    first_resp = rresp;
    stall      = draw_stall();
    repeat (stall) begin
      @(negedge clk);
      if (!rvalid || rdata !== first || rresp !== first_resp) begin
        report_failure("R response dropped or changed while rready was low");
      end
      if (arready !== 1'b0) begin
        report_failure("arready was high while an R response was still pending");
      end
    end
    data   = rdata;
    resp   = rresp;
    rready = 1'b1;
    @(negedge clk);
    rready = 1'b0;
  endtask

  // --------------------------------------------------
  // division sequences
  // --------------------------------------------------
  task automatic start_div(input string name, input div_op_e op,
                           input logic [31:0] a, input logic [31:0] b);
    axil_resp_e             resp;
    logic [AXIL_DATA_W-1:0] ctrl;
    ctrl                  = '0;
    ctrl[CTRL_START_BIT]  = 1'b1;
    ctrl[CTRL_SIGNED_BIT] = (op == OP_SIGNED);
    axil_write(REG_DIVIDEND, a, resp);
    check_resp({name, " dividend write"}, RESP_OKAY, resp);
    axil_write(REG_DIVISOR, b, resp);
    check_resp({name, " divisor write"}, RESP_OKAY, resp);
    axil_write(REG_CTRL, ctrl, resp);
    check_resp({name, " start write"}, RESP_OKAY, resp);
  endtask

  // poll status until done, then hand the result to the checker
  task automatic finish_div(input string name, input div_op_e op,
                            input logic [31:0] a, input logic [31:0] b);
    axil_resp_e             resp;
    logic [AXIL_DATA_W-1:0] st;
    logic [AXIL_DATA_W-1:0] quo;
    logic [AXIL_DATA_W-1:0] rem;
    int                     polls;
    st    = '0;
    polls = 0;
    while (!st[STATUS_DONE_BIT]) begin
      if (polls == POLL_LIMIT) begin
        report_failure({name, ": status never showed done"});
      end
      axil_read(REG_STATUS, st, resp);
      check_resp({name, " status read"}, RESP_OKAY, resp);
      polls++;
    end
    check_data({name, " busy when done"}, '0, AXIL_DATA_W'(st[STATUS_BUSY_BIT]));
    axil_read(REG_QUOTIENT, quo, resp);
    check_resp({name, " quotient read"}, RESP_OKAY, resp);
    axil_read(REG_REMAINDER, rem, resp);
    check_resp({name, " remainder read"}, RESP_OKAY, resp);
    name_q.push_back(name);
    op_q.push_back(op);
    a_q.push_back(a);
    b_q.push_back(b);
    quo_q.push_back(quo);
    rem_q.push_back(rem);
    dz_q.push_back(st[STATUS_DZ_BIT]);
    n_sent++;
    -> result_ev;
  endtask

  task automatic run_div(input string name, input div_op_e op,
                         input logic [31:0] a, input logic [31:0] b);
    start_div(name, op, a, b);
    finish_div(name, op, a, b);
  endtask

  initial begin : compare_results
    string       name;
    div_op_e     op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] exp_q;
    logic [31:0] exp_r;
    logic        exp_dz;
    forever begin
      while (name_q.size() == 0) @(result_ev);
      name = name_q.pop_front();
      op   = op_q.pop_front();
      a    = a_q.pop_front();
      b    = b_q.pop_front();
      ref_div(op, a, b, exp_q, exp_r, exp_dz);
      check_data({name, " quotient"}, exp_q, quo_q.pop_front());
      check_data({name, " remainder"}, exp_r, rem_q.pop_front());
      check_data({name, " zero divisor"}, AXIL_DATA_W'(exp_dz), AXIL_DATA_W'(dz_q.pop_front()));
      n_checked++;
    end
  end

  initial begin : watchdog
    #(NUM_TESTS * 200 * CLK_PERIOD);
    $display("timeout: the tests did not finish in %0d ns", NUM_TESTS * 200 * CLK_PERIOD);
    $display("Simulation FAILED");
    $fatal(1, "watchdog expired");
  end

  // --------------------------------------------------
  // test sequence
  // --------------------------------------------------
  initial begin : stimulus
    logic [31:0]            a;
    logic [31:0]            b;
    logic [AXIL_DATA_W-1:0] data;
    axil_resp_e             resp;
    logic [31:0]            dir_a[N_DIR_U];
    logic [31:0]            dir_b[N_DIR_U];
    logic [31:0]            sdir_a[N_DIR_S];
    logic [31:0]            sdir_b[N_DIR_S];
    void'($urandom(59));
    dir_a   = '{100, 7, 0, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h8000_0000, 12345678};
    dir_b   = '{7, 100, 5, 1, 32'hFFFF_FFFF, 3, 32'h0001_0000};
    sdir_a  = '{100, -100, 100, -100, 32'h8000_0000, 32'h8000_0000, -1, 7};
    sdir_b  = '{7, 7, -7, -7, -1, 1, 32'h8000_0000, -1};
    clk     = 1'b0;
    arst_n  = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    bp_max  = 0;
    n_sent    = 0;
    n_checked = 0;
    repeat (2) @(negedge clk);
    arst_n = 1'b1;

    axil_read(REG_STATUS, data, resp);
    check_resp("status after reset resp", RESP_OKAY, resp);
    check_data("status after reset", '0, data);

    for (int i = 0; i < N_DIR_U; i++) begin
      run_div($sformatf("unsigned directed %0d", i), OP_UNSIGNED, dir_a[i], dir_b[i]);
    end
    for (int i = 0; i < N_RAND_U; i++) begin
      a = $urandom();
      b = $urandom() >> $urandom_range(0, 31);
      run_div($sformatf("unsigned random %0d", i), OP_UNSIGNED, a, b);
    end

    for (int i = 0; i < N_DIR_S; i++) begin
      run_div($sformatf("signed directed %0d", i), OP_SIGNED, sdir_a[i], sdir_b[i]);
    end
    for (int i = 0; i < N_RAND_S; i++) begin
      a = $urandom();
      b = $urandom() >> $urandom_range(0, 31);
      if ($urandom_range(0, 1) == 1) begin
        b = -b;
      end
      run_div($sformatf("signed random %0d", i), OP_SIGNED, a, b);
    end

    // zero divisor, each one followed by a normal division
    run_div("unsigned by zero", OP_UNSIGNED, 32'd987654, 32'd0);
    run_div("after unsigned by zero", OP_UNSIGNED, 32'd987654, 32'd3);
    run_div("signed by zero", OP_SIGNED, -32'd4242, 32'd0);
    run_div("after signed by zero", OP_SIGNED, -32'd4242, 32'd5);

    // start while busy is refused and leaves the running division alone
    start_div("busy start", OP_SIGNED, -32'd5000, 32'd33);
    axil_read(REG_STATUS, data, resp);
    check_data("busy status", 32'd1, AXIL_DATA_W'(data[STATUS_BUSY_BIT]));
    data = '0;
    data[CTRL_START_BIT] = 1'b1;
    axil_write(REG_CTRL, data, resp);
    check_resp("start while busy", RESP_SLVERR, resp);
    finish_div("busy start", OP_SIGNED, -32'd5000, 32'd33);

    // register map checks
    axil_write(REG_STATUS, 32'h7, resp);
    check_resp("status write", RESP_SLVERR, resp);
    axil_write(REG_QUOTIENT, 32'h1, resp);
    check_resp("quotient write", RESP_SLVERR, resp);
    axil_write(5'h18, 32'h1, resp);
    check_resp("unmapped write", RESP_SLVERR, resp);
    axil_read(5'h1C, data, resp);
    check_resp("unmapped read", RESP_SLVERR, resp);
    axil_write(REG_DIVIDEND, 32'hDEAD_BEEF, resp);
    check_resp("dividend write", RESP_OKAY, resp);
    axil_write(REG_DIVISOR, 32'h0BAD_F00D, resp);
    check_resp("divisor write", RESP_OKAY, resp);
    axil_read(REG_DIVIDEND, data, resp);
    check_resp("dividend read resp", RESP_OKAY, resp);
    check_data("dividend read", 32'hDEAD_BEEF, data);
    axil_read(REG_DIVISOR, data, resp);
    check_resp("divisor read resp", RESP_OKAY, resp);
    check_data("divisor read", 32'h0BAD_F00D, data);

    // random back-pressure on bready and rready
    bp_max = 6;
    for (int i = 0; i < N_BP; i++) begin
      a = $urandom();
      b = $urandom() >> $urandom_range(0, 31);
      run_div($sformatf("back-pressure %0d", i), div_op_e'(i % 2), a, b);
    end

    while (n_checked != n_sent) @(negedge clk);
    $display("Simulation PASSED");
    $finish;
  end

endmodule

// ==== flist.f ====
div_pkg.sv
div_axil_decode.sv
div_iter_ctrl.sv
div_iterative.sv
div_result.sv
div_top.sv
tb_div_top.sv

// ==== Bender.yml ====
package:
  name: div_axil

sources:
  - div_pkg.sv
  - div_axil_decode.sv
  - div_iter_ctrl.sv
  - div_iterative.sv
  - div_result.sv
  - div_top.sv
  - target: test
    files:
      - tb_div_top.sv
